/* hw/serial_pkg.sv */
/*
 * shared types and constants for the 3-wire serial master
 * WORD_BITS and FIFO_DEPTH should stay powers of two, CLK_DIV at least 2
 */

package serial_pkg;

	// ------------------------------------------------------------------
	// link parameters
	// ------------------------------------------------------------------

	// bits per serial word
	localparam int WORD_BITS = 8;

	// in_clk cycles per serial clock half period
	localparam int CLK_DIV = 4;

	// bit order on the wire, 1 = low bit first
	localparam bit LSB_FIRST = 1'b1;

	// entries per queue
	localparam int FIFO_DEPTH = 8;

	// longest transaction in words
	localparam int MAX_WORDS = 15;
	localparam int CNT_BITS = $clog2(MAX_WORDS + 1);

	// ------------------------------------------------------------------
	// payload and handshake types
	// ------------------------------------------------------------------

	typedef logic [WORD_BITS-1:0] word_t;

	// received word, last marks the end of its frame
	typedef struct packed {
		word_t word;
		logic  last;
	} rx_entry_t;

	// host command, count of 0 is ignored
	typedef struct packed {
		logic [CNT_BITS-1:0] count;
	} cmd_t;

	typedef struct packed {
		logic [CNT_BITS-1:0] words_done;
		logic                underrun;
		logic                overflow;
	} status_t;

endpackage

/* hw/serial_clkgen.sv */
/*
 * serial clock divider with tick strobes, sclk idles high while run is low
 * each run period starts with a full low half period
 */

module serial_clkgen (
	input  logic in_clk,
	input  logic in_rst,
	input  logic run,
	output logic sclk,
	output logic fall_tick,
	output logic rise_tick
);
	import serial_pkg::*;

	localparam int DIV_BITS = $clog2(CLK_DIV);
	localparam logic [DIV_BITS-1:0] DIV_LAST = DIV_BITS'(CLK_DIV - 1);

	// position inside the current half period
	logic [DIV_BITS-1:0] div_cnt;
	// set during the high half of a bit
	logic high_half;
	logic half_end;

	// ------------------------------------------------------------------
	// tick strobes
	// ------------------------------------------------------------------

	// last cycle of a half period
	assign half_end = run && (div_cnt == DIV_LAST);

	// strobes mark the cycle whose closing edge toggles the level
	assign fall_tick = half_end && high_half;
	assign rise_tick = half_end && !high_half;

	// held high when stopped
	assign sclk = !run || high_half;

	// ------------------------------------------------------------------
	// divider
	// ------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			div_cnt <= '0;
			high_half <= 1'b0;
		end else if (!run) begin
			// restart in the low half next time
			div_cnt <= '0;
			high_half <= 1'b0;
		end else if (half_end) begin
			div_cnt <= '0;
			high_half <= !high_half;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* hw/serial_shifter.sv */
/*
 * shifts one word out on sdo and one word in from sdi per load strobe
 * load must not arrive before word_done of the previous word
 */

module serial_shifter #(
	parameter bit lsb_first = serial_pkg::LSB_FIRST
) (
	input  logic               in_clk,
	input  logic               in_rst,
	input  logic               load,
	input  serial_pkg::word_t  load_word,
	input  logic               sdi,
	output logic               sclk,
	output logic               sdo,
	output logic               word_done,
	output serial_pkg::word_t  rx_word
);
	import serial_pkg::*;

	localparam int BIT_BITS = $clog2(WORD_BITS);
	localparam logic [BIT_BITS-1:0] LAST_BIT = BIT_BITS'(WORD_BITS - 1);

	// word in flight
	logic running;

	// bits already shifted in this word
	logic [BIT_BITS-1:0] bit_cnt;
	// bit counter mapped to the wire order
	logic [BIT_BITS-1:0] actual_bit;

	word_t tx_reg;
	word_t rx_reg;

	logic fall_tick;
	logic rise_tick;

	// ------------------------------------------------------------------
	// bit order
	// ------------------------------------------------------------------
	generate
		if (lsb_first) begin : g_lsb
			assign actual_bit = bit_cnt;
		end else begin : g_msb
			assign actual_bit = LAST_BIT - bit_cnt;
		end
	endgenerate

	// ------------------------------------------------------------------
	// serial clock
	// ------------------------------------------------------------------
	serial_clkgen i_clkgen (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.run      (running),
		.sclk     (sclk),
		.fall_tick(fall_tick),
		.rise_tick(rise_tick)
	);

	// data line idles high
	assign sdo = running ? tx_reg[actual_bit] : 1'b1;

	// closing fall tick of the last bit ends the word
	assign word_done = running && fall_tick && (bit_cnt == LAST_BIT);

	assign rx_word = rx_reg;

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			running <= 1'b0;
			bit_cnt <= '0;
		end else if (load) begin
			running <= 1'b1;
			bit_cnt <= '0;
		end else if (running && fall_tick) begin
			if (bit_cnt == LAST_BIT) begin
				// stop, sclk back to idle
				running <= 1'b0;
				bit_cnt <= '0;
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// payload registers
	always_ff @(posedge in_clk) begin
		if (load) begin
			tx_reg <= load_word;
		end
		// sample on the rising sclk edge
		if (running && rise_tick) begin
			rx_reg[actual_bit] <= sdi;
		end
	end

	// controller waits for word_done before the next load
	a_no_load_busy : assert property (
		@(posedge in_clk) disable iff (in_rst) load |-> !running
	) else $error("load while a word is still shifting");

endmodule

/* hw/word_fifo.sv */
/*
 * synchronous queue, FIFO_DEPTH must be a power of two
 * push on full is dropped, pop on empty is ignored, head is stale when empty
 */

module word_fifo #(
	parameter type payload_t = serial_pkg::word_t
) (
	input  logic     in_clk,
	input  logic     in_rst,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t head,
	output logic     empty,
	output logic     full
);
	import serial_pkg::*;

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);
	localparam int OCC_BITS = $clog2(FIFO_DEPTH + 1);

	payload_t mem [FIFO_DEPTH];

	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	// number of stored entries
	logic [OCC_BITS-1:0] occ;

	logic do_push;
	logic do_pop;

	// ------------------------------------------------------------------
	// flags and accepted operations
	// ------------------------------------------------------------------
	assign empty = (occ == '0);
	assign full = (occ == OCC_BITS'(FIFO_DEPTH));

	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// oldest entry always visible
	assign head = mem[rd_ptr];

	// storage
	always_ff @(posedge in_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap on their own
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			occ <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: occ <= occ + 1'b1;
				2'b01: occ <= occ - 1'b1;
				default: ;
			endcase
		end
	end

	a_occ_bound : assert property (
		@(posedge in_clk) disable iff (in_rst) occ <= OCC_BITS'(FIFO_DEPTH)
	) else $error("queue occupancy above depth");

endmodule

/* hw/serial_ctrl.sv */
/*
 * transaction sequencer, commands are taken only while busy is low
 * underrun is decided when the transmit queue is empty at a word boundary
 */

module serial_ctrl (
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  cmd_valid,
	input  serial_pkg::cmd_t      cmd,
	input  logic                  tx_empty,
	input  serial_pkg::word_t     tx_head,
	input  logic                  word_done,
	input  serial_pkg::word_t     rx_word,
	input  logic                  rx_full,
	output logic                  tx_pop,
	output logic                  load,
	output serial_pkg::word_t     load_word,
	output logic                  rx_push,
	output serial_pkg::rx_entry_t rx_data,
	output logic                  sel_n,
	output logic                  busy,
	output logic                  done,
	output serial_pkg::status_t   status
);
	import serial_pkg::*;

	typedef enum logic [1:0] {st_idle, st_load, st_shift, st_finish} state_t;

	state_t state;
	// words still owed, current one included
	logic [CNT_BITS-1:0] remaining;
	status_t stat_q;

	logic cmd_take;
	logic last_word;

	// ------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------

	// finish cycle counts as idle for the host
	assign busy = (state == st_load) || (state == st_shift);
	assign done = (state == st_finish);
	assign status = stat_q;

	// zero count ignored
	assign cmd_take = cmd_valid && !busy && (cmd.count != '0);

	// pop and load together
	assign tx_pop = (state == st_load) && !tx_empty;
	assign load = tx_pop;
	assign load_word = tx_head;

	// final word by count or by empty queue
	assign last_word = (remaining == CNT_BITS'(1)) || tx_empty;

	assign rx_push = (state == st_shift) && word_done;
	assign rx_data = '{word: rx_word, last: last_word};

	// ------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------
	always_ff @(posedge in_clk) begin
		if (in_rst) begin
			state <= st_idle;
			sel_n <= 1'b1;
			remaining <= '0;
			stat_q <= '0;
		end else begin
			case (state)
				st_idle, st_finish: begin
					if (cmd_take) begin
						state <= st_load;
						sel_n <= 1'b0;
						remaining <= cmd.count;
						stat_q <= '0;
					end else begin
						state <= st_idle;
					end
				end
				st_load: begin
					// nothing to send for the first word
					if (tx_empty) begin
						stat_q.underrun <= 1'b1;
						sel_n <= 1'b1;
						state <= st_finish;
					end else begin
						state <= st_shift;
					end
				end
				st_shift: begin
					if (word_done) begin
						remaining <= remaining - 1'b1;
						stat_q.words_done <= stat_q.words_done + 1'b1;
						// entry lost in the receive queue
						if (rx_full) begin
							stat_q.overflow <= 1'b1;
						end
						if (last_word) begin
							if (remaining != CNT_BITS'(1)) begin
								stat_q.underrun <= 1'b1;
							end
							sel_n <= 1'b1;
							state <= st_finish;
						end else begin
							state <= st_load;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	a_done_pulse : assert property (
		@(posedge in_clk) disable iff (in_rst) done |=> !done
	) else $error("done held for more than one cycle");

endmodule

/* hw/serial_top.sv */
/*
 * 3-wire serial master with transmit and receive queues
 * single clock domain, no back-pressure on either queue
 */

module serial_top (
	input  logic                  in_clk,
	input  logic                  in_rst,
	input  logic                  tx_push,
	input  serial_pkg::word_t     tx_word,
	input  logic                  cmd_valid,
	input  serial_pkg::cmd_t      cmd,
	input  logic                  rx_pop,
	input  logic                  sdi,
	output logic                  tx_full,
	output serial_pkg::rx_entry_t rx_head,
	output logic                  rx_empty,
	output logic                  busy,
	output logic                  done,
	output serial_pkg::status_t   status,
	output logic                  sclk,
	output logic                  sdo,
	output logic                  sel_n
);
	import serial_pkg::*;

	// transmit queue to controller
	logic  tx_empty;
	logic  tx_pop;
	word_t tx_head;

	// controller and shifter
	logic  load;
	word_t load_word;
	logic  word_done;
	word_t rx_word;

	// controller to receive queue
	logic      rx_push;
	logic      rx_full;
	rx_entry_t rx_data;

	// ------------------------------------------------------------------
	// queues
	// ------------------------------------------------------------------
	word_fifo #(.payload_t(word_t)) i_tx_fifo (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.push     (tx_push),
		.push_data(tx_word),
		.pop      (tx_pop),
		.head     (tx_head),
		.empty    (tx_empty),
		.full     (tx_full)
	);

	word_fifo #(.payload_t(rx_entry_t)) i_rx_fifo (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.push     (rx_push),
		.push_data(rx_data),
		.pop      (rx_pop),
		.head     (rx_head),
		.empty    (rx_empty),
		.full     (rx_full)
	);

	// ------------------------------------------------------------------
	// sequencer and shifter
	// ------------------------------------------------------------------
	serial_ctrl i_ctrl (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.tx_empty (tx_empty),
		.tx_head  (tx_head),
		.word_done(word_done),
		.rx_word  (rx_word),
		.rx_full  (rx_full),
		.tx_pop   (tx_pop),
		.load     (load),
		.load_word(load_word),
		.rx_push  (rx_push),
		.rx_data  (rx_data),
		.sel_n    (sel_n),
		.busy     (busy),
		.done     (done),
		.status   (status)
	);

	serial_shifter i_shifter (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.load     (load),
		.load_word(load_word),
		.sdi      (sdi),
		.sclk     (sclk),
		.sdo      (sdo),
		.word_done(word_done),
		.rx_word  (rx_word)
	);

endmodule

/* tb/serial_ic_model.sv */
/*
 * behavioral peripheral IC, watches sclk edges on in_clk, same bit order as the master
 * answers 8'h3C to the first word of a frame, later words get the inverse of the last word heard
 */

module serial_ic_model (
	input  logic              in_clk,
	input  logic              sclk,
	input  logic              sdo,
	input  logic              sel_n,
	output logic              sdi,
	output serial_pkg::word_t last_rx,
	output int                rx_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import serial_pkg::*;

	localparam int IDX_BITS = $clog2(WORD_BITS);
	localparam logic [IDX_BITS-1:0] LAST_IDX = IDX_BITS'(WORD_BITS - 1);
	localparam word_t FIRST_ANSWER = 8'h3C;

	// sclk one in_clk earlier, for edge detection
	logic sclk_q = 1'b1;
	logic [IDX_BITS-1:0] bit_cnt = '0;
	logic [IDX_BITS-1:0] wire_idx;
	// word to return in the current slot
	word_t answer = FIRST_ANSWER;
	word_t heard = '0;
	word_t last_q = '0;
	logic sdi_q = 1'b1;
	int count_q = 0;

	assign wire_idx = LSB_FIRST ? bit_cnt : LAST_IDX - bit_cnt;
	assign sdi = sdi_q;
	assign last_rx = last_q;
	assign rx_count = count_q;

	always @(posedge in_clk) begin : edge_watch
		word_t got;
		got = heard;
		got[wire_idx] = sdo;
		sclk_q <= sclk;
		if (sel_n) begin
			// between frames, next word is a first word again
			bit_cnt <= '0;
			answer <= FIRST_ANSWER;
			sdi_q <= 1'b1;
		end else if (sclk_q && !sclk) begin
			// falling sclk, present the next answer bit
			sdi_q <= answer[wire_idx];
		end else if (!sclk_q && sclk) begin
			// rising sclk, take the master's bit
			heard <= got;
			if (bit_cnt == LAST_IDX) begin
				bit_cnt <= '0;
				answer <= ~got;
				last_q <= got;
				count_q <= count_q + 1;
			end else begin
				bit_cnt <= bit_cnt + IDX_BITS'(1);
			end
		end
	end

endmodule

/* tb/tb_serial.sv */
/*
 * testbench for serial_top, operations come from tb/serial_stim.txt
 * run from the project root so the stimulus path resolves
 */

module tb_serial;
	timeunit 1ns;
	timeprecision 100ps;
	import serial_pkg::*;

	localparam int DONE_TIMEOUT = 2000;
	localparam int FULL_TIMEOUT = 300;
	localparam word_t FIRST_ANSWER = 8'h3C;
	// one word of 8 bits at 8 cycles each, plus the reload cycle
	localparam int WORD_CYCLES = 65;

	logic in_clk;
	logic in_rst;
	logic tx_push;
	word_t tx_word;
	logic cmd_valid;
	cmd_t cmd;
	logic rx_pop;
	logic sdi;
	logic tx_full;
	rx_entry_t rx_head;
	logic rx_empty;
	logic busy;
	logic done;
	status_t status;
	logic sclk;
	logic sdo;
	logic sel_n;

	// IC model view of the link
	word_t ic_last;
	int ic_count;

	int cycle = 0;
	int errors = 0;
	int test_errs = 0;
	int tests = 0;
	int tests_bad = 0;
	bit timed_out = 1'b0;
	bit file_bad = 1'b0;
	int seed = 70010;

	// frame bookkeeping
	bit frame_open = 1'b0;
	int cmd_cycle;
	int ic_count_at_cmd;
	word_t last_pushed;
	word_t rnd_words[$];

	// ------------------------------------------------------------------
	// DUT and peripheral
	// ------------------------------------------------------------------
	serial_top i_dut (
		.in_clk   (in_clk),
		.in_rst   (in_rst),
		.tx_push  (tx_push),
		.tx_word  (tx_word),
		.cmd_valid(cmd_valid),
		.cmd      (cmd),
		.rx_pop   (rx_pop),
		.sdi      (sdi),
		.tx_full  (tx_full),
		.rx_head  (rx_head),
		.rx_empty (rx_empty),
		.busy     (busy),
		.done     (done),
		.status   (status),
		.sclk     (sclk),
		.sdo      (sdo),
		.sel_n    (sel_n)
	);

	serial_ic_model i_ic (
		.in_clk  (in_clk),
		.sclk    (sclk),
		.sdo     (sdo),
		.sel_n   (sel_n),
		.sdi     (sdi),
		.last_rx (ic_last),
		.rx_count(ic_count)
	);

	always #10 in_clk = ~in_clk;

	// edge count, read at falling edges only
	always @(posedge in_clk) cycle <= cycle + 1;

	// ------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------
	task automatic report_err(input string msg);
		errors++;
		test_errs++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	// new cycle, all strobes back low
	task automatic start_cycle();
		@(posedge in_clk);
		tx_push <= 1'b0;
		cmd_valid <= 1'b0;
		rx_pop <= 1'b0;
	endtask

	task automatic check_idle();
		start_cycle();
		@(negedge in_clk);
		if (!sel_n || !sclk || !sdo) begin
			report_err($sformatf("serial lines not idle: sel_n %b sclk %b sdo %b",
				sel_n, sclk, sdo));
		end
		if (busy || done) begin
			report_err($sformatf("busy %b done %b after reset", busy, done));
		end
		if (!rx_empty || tx_full) begin
			report_err($sformatf("queues not empty: rx_empty %b tx_full %b", rx_empty, tx_full));
		end
	endtask

	// host waits while the transmit queue is full
	task automatic push_word(input word_t w);
		int guard;
		guard = 0;
		start_cycle();
		@(negedge in_clk);
		while (tx_full && guard < FULL_TIMEOUT) begin
			start_cycle();
			@(negedge in_clk);
			guard++;
		end
		if (tx_full) begin
			$display("timeout: transmit queue stayed full for %0d cycles", FULL_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			@(posedge in_clk);
			tx_push <= 1'b1;
			tx_word <= w;
			last_pushed = w;
		end
	endtask

	task automatic send_cmd(input int count);
		start_cycle();
		cmd_valid <= 1'b1;
		cmd <= '{count: CNT_BITS'(count)};
		@(negedge in_clk);
		// a command inside an open frame must be ignored
		if (!frame_open) begin
			frame_open = 1'b1;
			cmd_cycle = cycle;
			ic_count_at_cmd = ic_count;
		end
	endtask

	task automatic wait_done(input int words, input bit underrun, input bit overflow);
		status_t exp_stat;
		int guard;
		bit seen;
		bit sel_bad;
		exp_stat.words_done = CNT_BITS'(words);
		exp_stat.underrun = underrun;
		exp_stat.overflow = overflow;
		guard = 0;
		seen = 1'b0;
		sel_bad = 1'b0;
		while (!seen && guard < DONE_TIMEOUT) begin
			start_cycle();
			@(negedge in_clk);
			guard++;
			if (done) begin
				seen = 1'b1;
			end else if (sel_n && !sel_bad) begin
				sel_bad = 1'b1;
				report_err("sel_n high inside the frame");
			end
		end
		if (!seen) begin
			$display("timeout: no done strobe within %0d cycles", DONE_TIMEOUT);
			timed_out = 1'b1;
		end else begin
			frame_open = 1'b0;
			if (status !== exp_stat) begin
				report_err($sformatf("status words %0d un %b ov %b, expected %0d un %b ov %b",
					status.words_done, status.underrun, status.overflow,
					words, underrun, overflow));
			end
			if (words != 0 && cycle - cmd_cycle != 1 + WORD_CYCLES * words) begin
				report_err($sformatf("done %0d cycles after command, expected %0d",
					cycle - cmd_cycle, 1 + WORD_CYCLES * words));
			end
			if (busy || !sel_n) begin
				report_err($sformatf("at done busy %b sel_n %b", busy, sel_n));
			end
			if (ic_count - ic_count_at_cmd != words) begin
				report_err($sformatf("IC heard %0d words, expected %0d",
					ic_count - ic_count_at_cmd, words));
			end
			if (words != 0 && ic_last !== last_pushed) begin
				report_err($sformatf("IC last word %h, expected %h", ic_last, last_pushed));
			end
		end
	endtask

	// check the head, then pop it
	task automatic pop_check(input word_t w, input bit last);
		start_cycle();
		@(negedge in_clk);
		if (rx_empty) begin
			report_err($sformatf("receive queue empty, expected %h", w));
		end else if (rx_head.word !== w || rx_head.last !== last) begin
			report_err($sformatf("rx entry %h last %b, expected %h last %b",
				rx_head.word, rx_head.last, w, last));
		end
		@(posedge in_clk);
		rx_pop <= 1'b1;
	endtask

	task automatic push_random(input int n);
		word_t w;
		for (int k = 0; k < n && !timed_out; k++) begin
			w = word_t'($random(seed));
			rnd_words.push_back(w);
			push_word(w);
		end
	endtask

	// answers by the IC rule for one frame of random words
	task automatic check_random(input int n);
		word_t exp_w;
		for (int k = 0; k < n; k++) begin
			exp_w = (k == 0) ? FIRST_ANSWER : ~rnd_words[k-1];
			pop_check(exp_w, k == n - 1);
		end
		rnd_words.delete();
	endtask

	task automatic end_test(input logic [8*24-1:0] name);
		start_cycle();
		@(negedge in_clk);
		if (!rx_empty) begin
			report_err("receive queue not empty at end of test");
		end
		if (busy) begin
			report_err("still busy at end of test");
		end
		tests++;
		if (test_errs == 0) begin
			$display("test %0s: ok", name);
		end else begin
			tests_bad++;
			$display("test %0s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		int fd;
		int code;
		int ch;
		int a;
		int b;
		int c;
		logic [7:0] op;
		logic [8*24-1:0] name;
		in_clk = 1'b0;
		in_rst = 1'b1;
		tx_push = 1'b0;
		tx_word = '0;
		cmd_valid = 1'b0;
		cmd = '0;
		rx_pop = 1'b0;
		repeat (8) @(posedge in_clk);
		in_rst <= 1'b0;
		fd = $fopen("tb/serial_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open stimulus file tb/serial_stim.txt");
			file_bad = 1'b1;
		end else begin
			code = $fscanf(fd, " %c", op);
			while (code == 1 && !timed_out && !file_bad) begin
				case (op)
					"#": begin
						// comment, skip to end of line
						ch = $fgetc(fd);
						while (ch != 10 && ch != -1) begin
							ch = $fgetc(fd);
						end
					end
					"I": check_idle();
					"P": begin
						code = $fscanf(fd, "%h", a);
						push_word(word_t'(a));
					end
					"R": begin
						code = $fscanf(fd, "%d", a);
						push_random(a);
					end
					"C": begin
						code = $fscanf(fd, "%d", a);
						send_cmd(a);
					end
					"D": begin
						code = $fscanf(fd, "%d %d %d", a, b, c);
						wait_done(a, b != 0, c != 0);
					end
					"G": begin
						code = $fscanf(fd, "%h %d", a, b);
						pop_check(word_t'(a), b != 0);
					end
					"H": begin
						code = $fscanf(fd, "%d", a);
						check_random(a);
					end
					"E": begin
						code = $fscanf(fd, "%s", name);
						end_test(name);
					end
					default: begin
						$display("unknown operation '%c' in stimulus file", op);
						file_bad = 1'b1;
					end
				endcase
				code = $fscanf(fd, " %c", op);
			end
			$fclose(fd);
		end
		$display("summary: %0d tests, %0d with errors, %0d errors in total",
			tests, tests_bad, errors);
		if (errors == 0 && !timed_out && !file_bad) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* tb/serial_stim.txt */
# ops: P word | R n random words | C count | D words underrun overflow | G word last
# H n checks random answers | I idle check | E test name (words and values in hex)
I
E reset_idle
P a5
C 1
D 1 0 0
G 3c 1
E single_word
P 12
P 34
P 56
P 78
C 4
D 4 0 0
G 3c 0
G ed 0
G cb 0
G a9 1
E multi_word
P 81
P 7e
C 5
D 2 1 0
G 3c 0
G 7e 1
E underrun
P 01
P 02
P 03
P 04
P 05
P 06
P 07
P 08
C 10
C 3
P 09
P 0a
D 10 0 1
G 3c 0
G fe 0
G fd 0
G fc 0
G fb 0
G fa 0
G f9 0
G f8 0
E overflow_busy
R 6
C 6
D 6 0 0
H 6
E random_words

/* flist.f */
hw/serial_pkg.sv
hw/serial_clkgen.sv
hw/serial_shifter.sv
hw/word_fifo.sv
hw/serial_ctrl.sv
hw/serial_top.sv
tb/serial_ic_model.sv
tb/tb_serial.sv

/* run_sim.sh */
#!/bin/sh
# builds and runs the serial master testbench with Verilator
# run from anywhere, works in the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_serial -o tb_serial_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_serial_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
